// ==== Bender.yml ====
package:
  name: cpu_controller

sources:
  - src/cpuCtrlPkg.sv
  - src/instrDecoder.sv
  - src/ctrlSequencer.sv
  - src/datapathControl.sv
  - src/cpuController.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tbCpuController.sv

// ==== src/cpuController.sv ====
`timescale 1ns/1ps

module cpuController import cpuCtrlPkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              stall,
    input  logic [WORD_W-1:0] opcode,     // Current instruction
    input  logic [FLAG_W-1:0] flags,
    output ctrlState_e        state,      // Visible for debug

    output logic [SEL_W-1:0]  memAddr,
    output logic              re,
    output logic              we,
    output logic              saveOpcode,
    output logic              saveMem,
    output logic              enPC,
    output aluFunc_t          aluFunc,
    output logic [SEL_W-1:0]  aluA,
    output logic [SEL_W-1:0]  aluB,
    output logic              enA,
    output logic              enB,
    output logic              enC,
    output logic              enF,
    output logic              enSP,
    output logic              initSP,
    output logic              isMul
);

    instrClass_e   instrClass;
    operandFetch_e operandFetch;

    instrDecoder decoder (
        .opcode       (opcode),
        .flags        (flags),
        .instrClass   (instrClass),
        .operandFetch (operandFetch)
    );

    ctrlSequencer sequencer (
        .clk          (clk),
        .rst          (rst),
        .stall        (stall),
        .instrClass   (instrClass),
        .operandFetch (operandFetch),
        .state        (state)
    );

    datapathControl outputDecode (
        .state      (state),
        .opcode     (opcode),
        .memAddr    (memAddr),
        .re         (re),
        .we         (we),
        .saveOpcode (saveOpcode),
        .saveMem    (saveMem),
        .enPC       (enPC),
        .aluFunc    (aluFunc),
        .aluA       (aluA),
        .aluB       (aluB),
        .enA        (enA),
        .enB        (enB),
        .enC        (enC),
        .enF        (enF),
        .enSP       (enSP),
        .initSP     (initSP),
        .isMul      (isMul)
    );

endmodule

// ==== src/cpuCtrlPkg.sv ====
package cpuCtrlPkg;

    localparam int WORD_W     = 16; // Instruction width
    localparam int REG_SEL_W  = 3;  // Width of a source or destination field
    localparam int ALU_FUNC_W = 4;
    localparam int SEL_W      = 4;  // ALU and memory select codes
    localparam int FLAG_W     = 4;

    // Opcode layout
    // Bits 15 to 12 give the class. 0000 is A-type and 0001 is SI-type.
    // 01xx is I-type, 11xx is JMP and 1000 is JMR.
    // 0010 with bit 8 clear is the flag branch. Any other pattern is illegal.
    // A-type keeps the ALU function in bits 8 to 5, the B source in bits 4 to 3
    // and the destination in bits 2 to 0.
    // I-type builds its function from bit 8, bit 8 and bits 13 to 12, and
    // writes back to s1. LDI is bits 13 to 12 set with bit 8 set.
    // SI-type builds its function as 10 plus bits 8 to 7, destination in bits 6 to 4.
    // The flag branch is taken when flags[bits 10 to 9] equals bit 11.
    localparam int CLS_MSB = 15;
    localparam int CLS_LSB = 12;
    localparam int S1_MSB  = 11; // Source 1 field at the same spot in every class
    localparam int S1_LSB  = 9;

    typedef enum logic [5:0] {
        START    = 6'b000000,
        FETCH    = 6'b000001,
        ATYPE    = 6'b000010,
        ITYPE    = 6'b000011,
        JMP      = 6'b000100,
        SITYPE   = 6'b000101,
        FTYPE    = 6'b000110,
        RIMMED   = 6'b010100, // Operand from (PC)
        RADDRESS = 6'b010101, // Operand from (A)
        JMR      = 6'b101100,
        HALT     = 6'b111111  // CPU stopped
    } ctrlState_e;

    typedef enum logic [2:0] {
        CLS_ATYPE,
        CLS_ITYPE,
        CLS_SITYPE,
        CLS_JMP,
        CLS_JMR,
        CLS_FTYPE,
        CLS_SKIP,   // Flag branch not taken
        CLS_ILLEGAL
    } instrClass_e;

    typedef enum logic [1:0] {
        FETCH_NONE,
        FETCH_IMMED,
        FETCH_INDIRECT,
        FETCH_ILLEGAL
    } operandFetch_e;

    typedef logic [ALU_FUNC_W-1:0] aluFunc_t;

    localparam aluFunc_t ALU_ADD  = 4'd0;
    localparam aluFunc_t ALU_SUB  = 4'd2;
    localparam aluFunc_t ALU_MUL  = 4'd4;
    localparam aluFunc_t ALU_JREL = 4'd6; // PC relative jump by register

    // Codes 0 to 3 of ALU input A pick reg 0, A, B, C
    localparam logic [SEL_W-1:0] ALU_A_PC  = 4'd4;
    localparam logic [SEL_W-1:0] ALU_A_MEM = 4'd5;
    localparam logic [SEL_W-1:0] ALU_A_SP  = 4'd6;

    // Codes 0 to 3 of ALU input B pick reg 0, A, B, C
    localparam logic [SEL_W-1:0] ALU_B_ONE  = 4'd4;
    localparam logic [SEL_W-1:0] ALU_B_ZERO = 4'd5;
    localparam logic [SEL_W-1:0] ALU_B_OP   = 4'd6; // Immediate field
    localparam logic [SEL_W-1:0] ALU_B_ADDR = 4'd7; // Jump offset
    localparam logic [SEL_W-1:0] ALU_B_MEM  = 4'd8;

    localparam logic [SEL_W-1:0] MEM_FROM_PC = 4'd0;
    localparam logic [SEL_W-1:0] MEM_FROM_A  = 4'd1;

    // Codes 5 to 7 have no target
    localparam logic [REG_SEL_W-1:0] DEST_ZERO = 3'd0;
    localparam logic [REG_SEL_W-1:0] DEST_A    = 3'd1;
    localparam logic [REG_SEL_W-1:0] DEST_B    = 3'd2;
    localparam logic [REG_SEL_W-1:0] DEST_C    = 3'd3;
    localparam logic [REG_SEL_W-1:0] DEST_ADR  = 3'd4; // Write to (A)

    // s1 values 0 to 3 are registers, 5 and 7 are illegal
    localparam logic [REG_SEL_W-1:0] SRC_IMMED    = 3'd4;
    localparam logic [REG_SEL_W-1:0] SRC_INDIRECT = 3'd6;

endpackage

// ==== src/ctrlSequencer.sv ====
`timescale 1ns/1ps

module ctrlSequencer import cpuCtrlPkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic          stall,        // Freezes the FSM
    input  instrClass_e   instrClass,
    input  operandFetch_e operandFetch,
    output ctrlState_e    state
);

    ctrlState_e nextState;
    ctrlState_e mainState; // Execute state of the current instruction

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= START;
        end else if (!stall) begin
            state <= nextState;
        end
    end

    always_comb begin
        case (instrClass)
            CLS_ATYPE:  mainState = ATYPE;
            CLS_ITYPE:  mainState = ITYPE;
            CLS_SITYPE: mainState = SITYPE;
            CLS_JMP:    mainState = JMP;
            CLS_JMR:    mainState = JMR;
            CLS_FTYPE:  mainState = FTYPE;
            CLS_SKIP:   mainState = FETCH; // Branch not taken
            default:    mainState = HALT;
        endcase
    end

    always_comb begin
        nextState = HALT; // Unknown state stops the CPU
        case (state)
            START: nextState = FETCH;
            FETCH: begin
                if (instrClass == CLS_ILLEGAL || operandFetch == FETCH_ILLEGAL) begin
                    nextState = HALT;
                end else if (operandFetch == FETCH_IMMED) begin
                    nextState = RIMMED;
                end else if (operandFetch == FETCH_INDIRECT) begin
                    nextState = RADDRESS;
                end else begin
                    nextState = mainState;
                end
            end
            // Operand is ready, go execute
            RIMMED, RADDRESS: nextState = mainState;
            ATYPE, ITYPE, SITYPE, JMP, JMR, FTYPE: nextState = FETCH;
            HALT: nextState = HALT; // Left only through reset
            default: nextState = HALT;
        endcase
    end

endmodule

// ==== src/datapathControl.sv ====
`timescale 1ns/1ps

module datapathControl import cpuCtrlPkg::*; (
    input  ctrlState_e        state,
    input  logic [WORD_W-1:0] opcode,

    output logic [SEL_W-1:0]  memAddr,    // Memory address source
    output logic              re,
    output logic              we,
    output logic              saveOpcode, // Instruction register load
    output logic              saveMem,    // Operand register load
    output logic              enPC,
    output aluFunc_t          aluFunc,
    output logic [SEL_W-1:0]  aluA,
    output logic [SEL_W-1:0]  aluB,
    output logic              enA,
    output logic              enB,
    output logic              enC,
    output logic              enF,        // Flag register load
    output logic              enSP,
    output logic              initSP,
    output logic              isMul
);

    logic [REG_SEL_W-1:0] s1;
    logic [REG_SEL_W-1:0] dest;       // Destination field of the current class
    logic                 writesDest;
    logic [SEL_W-1:0]     srcA;       // s1 as an ALU A source
    logic [SEL_W-1:0]     srcB;       // s1 as an ALU B source

    assign s1 = opcode[S1_MSB:S1_LSB];

    // Memory modes have already loaded the operand register
    assign srcA = s1[2] ? ALU_A_MEM : SEL_W'(s1[1:0]);
    assign srcB = s1[2] ? ALU_B_MEM : SEL_W'(s1[1:0]);

    always_comb begin
        memAddr    = MEM_FROM_PC;
        re         = 1'b0;
        we         = 1'b0;
        saveOpcode = 1'b0;
        saveMem    = 1'b0;
        enPC       = 1'b0;
        aluFunc    = ALU_ADD;
        aluA       = '0;
        aluB       = '0;
        enA        = 1'b0;
        enB        = 1'b0;
        enC        = 1'b0;
        enF        = 1'b0;
        enSP       = 1'b0;
        initSP     = 1'b0;
        isMul      = 1'b0;
        dest       = DEST_ZERO;
        writesDest = 1'b0;

        case (state)
            START: begin
                initSP = 1'b1;
                enSP   = 1'b1;
            end

            // Both read (PC) and step the PC
            FETCH, RIMMED: begin
                memAddr    = MEM_FROM_PC;
                re         = 1'b1;
                saveOpcode = (state == FETCH);
                saveMem    = (state == RIMMED);
                aluFunc    = ALU_ADD;
                aluA       = ALU_A_PC;
                aluB       = ALU_B_ONE;
                enPC       = 1'b1;
            end

            RADDRESS: begin
                memAddr = MEM_FROM_A; // Operand from (A)
                re      = 1'b1;
                saveMem = 1'b1;
            end

            ATYPE: begin
                aluA    = srcA;
                aluB    = SEL_W'(opcode[4:3]);
                aluFunc = opcode[8:5];
                enF     = |opcode; // NOP leaves flags alone
                if (opcode[8:5] == ALU_MUL) begin
                    enA   = 1'b1; // High word goes to A
                    isMul = 1'b1;
                end
                dest       = opcode[2:0];
                writesDest = 1'b1;
            end

            ITYPE: begin
                if (s1 == 3'b000) begin
                    aluA = ALU_A_SP;
                end else begin
                    aluA = srcA;
                end
                aluFunc = {opcode[8], opcode[8], opcode[13:12]};
                aluB    = ALU_B_OP;
                enF     = 1'b1;
                if (s1 == DEST_ZERO) begin
                    enSP = 1'b1; // Stack pointer arithmetic
                end
                dest       = s1;
                writesDest = 1'b1;
            end

            SITYPE: begin
                aluA       = srcA;
                aluFunc    = {2'b10, opcode[8:7]}; // Shift group
                aluB       = ALU_B_OP;
                enF        = 1'b1;
                dest       = opcode[6:4];
                writesDest = 1'b1;
            end

            JMP: begin
                aluA    = ALU_A_PC;
                aluB    = ALU_B_ADDR;
                aluFunc = ALU_ADD;
                enPC    = 1'b1;
            end

            JMR: begin
                aluA    = ALU_A_PC;
                aluB    = srcB;
                aluFunc = ALU_JREL;
                enPC    = 1'b1;
            end

            FTYPE: begin
                aluA    = ALU_A_PC;
                aluB    = ALU_B_OP; // Branch offset
                aluFunc = ALU_ADD;
                enPC    = 1'b1;
            end

            default: begin end // HALT drives nothing
        endcase

        if (writesDest) begin
            case (dest)
                DEST_A: enA = 1'b1;
                DEST_B: enB = 1'b1;
                DEST_C: enC = 1'b1;
                DEST_ADR: begin
                    we      = 1'b1; // ALU result to (A)
                    memAddr = MEM_FROM_A;
                end
                default: begin end
            endcase
        end
    end

endmodule

// ==== src/instrDecoder.sv ====
`timescale 1ns/1ps

module instrDecoder import cpuCtrlPkg::*; (
    input  logic [WORD_W-1:0] opcode,     // Current instruction
    input  logic [FLAG_W-1:0] flags,      // Current flag register
    output instrClass_e       instrClass,
    output operandFetch_e     operandFetch
);

    logic [REG_SEL_W-1:0] s1;
    logic                 condTrue;
    logic                 isLdi;
    logic                 readsMem;

    assign s1 = opcode[S1_MSB:S1_LSB];

    // Flag selected by bits 10 to 9 compared with bit 11
    assign condTrue = (flags[opcode[10:9]] == opcode[11]);

    always_comb begin
        instrClass = CLS_ILLEGAL; // Unknown groups stop the CPU
        casez (opcode[CLS_MSB:CLS_LSB])
            4'b0000: instrClass = CLS_ATYPE;
            4'b01??: instrClass = CLS_ITYPE;
            4'b11??: instrClass = CLS_JMP;
            4'b1000: instrClass = CLS_JMR;
            4'b0001: instrClass = CLS_SITYPE;
            4'b0010: begin
                if (!opcode[8]) begin // Bit 8 set was load/save
                    instrClass = condTrue ? CLS_FTYPE : CLS_SKIP;
                end
            end
            default: instrClass = CLS_ILLEGAL;
        endcase
    end

    // LDI takes the immediate field directly
    assign isLdi = (instrClass == CLS_ITYPE) && opcode[8] && (opcode[13:12] == 2'b11);

    // Only these classes take s1 as a data source
    always_comb begin
        case (instrClass)
            CLS_ATYPE, CLS_ITYPE, CLS_SITYPE, CLS_JMR: readsMem = 1'b1;
            default:                                   readsMem = 1'b0;
        endcase
    end

    always_comb begin
        if (!s1[2] || !readsMem || isLdi) begin // Register source or no read
            operandFetch = FETCH_NONE;
        end else begin
            case (s1)
                SRC_IMMED:    operandFetch = FETCH_IMMED;
                SRC_INDIRECT: operandFetch = FETCH_INDIRECT;
                default:      operandFetch = FETCH_ILLEGAL; // Absolute and stack modes
            endcase
        end
    end

endmodule

// ==== tb.f ====
+incdir+tests
src/cpuCtrlPkg.sv
src/instrDecoder.sv
src/ctrlSequencer.sv
src/datapathControl.sv
src/cpuController.sv
tests/tbCpuController.sv

// ==== tests/tbChecks.svh ====
int          checkCount = 0;
int          errCount   = 0;
int          errAtStart = 0;      // Errors seen before the current test
string       curTest    = "none";
int unsigned lcgState   = 35797;

// 32-bit LCG returning its upper half
function automatic int unsigned nextRandom(input int unsigned range);
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return (lcgState >> 16) % range;
endfunction

task automatic checkState(input string what, input ctrlState_e expected,
                          input ctrlState_e actual);
    checkCount++;
    if (actual !== expected) begin
        errCount++;
        $display("FAILED %s: %s expected %s actual %s (%b)", curTest, what,
                 expected.name(), actual.name(), actual);
    end
endtask

task automatic checkBit(input string what, input logic expected, input logic actual);
    checkCount++;
    if (actual !== expected) begin
        errCount++;
        $display("FAILED %s: %s expected %b actual %b", curTest, what, expected, actual);
    end
endtask

task automatic checkSel(input string what, input logic [SEL_W-1:0] expected,
                        input logic [SEL_W-1:0] actual);
    checkCount++;
    if (actual !== expected) begin
        errCount++;
        $display("FAILED %s: %s expected %0d actual %0d", curTest, what, expected, actual);
    end
endtask

task automatic checkFunc(input string what, input aluFunc_t expected, input aluFunc_t actual);
    checkCount++;
    if (actual !== expected) begin
        errCount++;
        $display("FAILED %s: %s expected %h actual %h", curTest, what, expected, actual);
    end
endtask

// ==== tests/tbCpuController.sv ====
`timescale 1ns/1ps

module tbCpuController import cpuCtrlPkg::*; ();

    logic              clk = 1'b0;
    logic              rst;
    logic              stall;
    logic [WORD_W-1:0] opcode;
    logic [FLAG_W-1:0] flags;
    ctrlState_e        state;
    logic [SEL_W-1:0]  memAddr;
    logic [SEL_W-1:0]  aluA;
    logic [SEL_W-1:0]  aluB;
    aluFunc_t          aluFunc;
    logic              re, we, saveOpcode, saveMem, enPC;
    logic              enA, enB, enC, enF, enSP, initSP, isMul;

    `include "tbChecks.svh"

    always #5 clk = ~clk; // 10 ns period

    cpuController uut (.*);

    task automatic nextCycle();
        @(negedge clk);
        #1;
    endtask

    // Ends on a falling edge so the caller can drive right away
    task automatic waitForState(input ctrlState_e target, input int maxCycles);
        int n;
        n = 0;
        @(negedge clk);
        while (state !== target && n < maxCycles) begin
            @(negedge clk);
            n++;
        end
        if (state !== target) begin
            errCount++;
            $display("Timeout in %s: state %s not reached within %0d cycles",
                     curTest, target.name(), maxCycles);
        end
    endtask

    task automatic startTest(input string name);
        curTest    = name;
        errAtStart = errCount;
    endtask

    task automatic endTest();
        if (errCount == errAtStart) begin
            $display("Test %s: ok", curTest);
        end else begin
            $display("Test %s: %0d errors", curTest, errCount - errAtStart);
        end
    endtask

    task automatic expectIdle();
        checkBit("any enable or strobe", 1'b0, re | we | saveOpcode | saveMem | enPC | enA |
                 enB | enC | enF | enSP | initSP | isMul);
        checkSel("any select or function", '0, memAddr | aluA | aluB | aluFunc);
    endtask

    // 16 rising edges with rst high, then the first fetch
    task automatic applyReset();
        rst = 1'b1;
        repeat (15) @(negedge clk);
        #1;
        checkState("state in reset", START, state);
        checkBit("initSP in reset", 1'b1, initSP);
        checkBit("enSP in reset", 1'b1, enSP);
        checkBit("we in reset", 1'b0, we);
        checkBit("re in reset", 1'b0, re);
        @(negedge clk);
        rst = 1'b0;
        #1;
        checkState("state after release", START, state);
        checkBit("initSP after release", 1'b1, initSP);
        checkBit("enSP after release", 1'b1, enSP);
        checkBit("we after release", 1'b0, we);
        checkBit("re after release", 1'b0, re);
        nextCycle();
        checkState("first fetch", FETCH, state);
        checkBit("re", 1'b1, re);
        checkBit("saveOpcode", 1'b1, saveOpcode);
        checkBit("enPC", 1'b1, enPC);
        checkSel("aluA", ALU_A_PC, aluA);
        checkSel("aluB", ALU_B_ONE, aluB);
        checkFunc("aluFunc", ALU_ADD, aluFunc);
    endtask

    task automatic runAtype(input logic [2:0] src, input aluFunc_t fn,
                            input logic [1:0] srcB, input logic [2:0] dest);
        logic [WORD_W-1:0] op;
        op = {4'b0000, src, fn, srcB, dest};
        waitForState(FETCH, 10);
        opcode = op;
        nextCycle();
        checkState("execute", ATYPE, state);
        checkSel("aluA", SEL_W'(src), aluA);
        checkSel("aluB", SEL_W'(srcB), aluB);
        checkFunc("aluFunc", fn, aluFunc);
        checkBit("enF", op != '0, enF); // NOP keeps the flags
        checkBit("enA", dest == DEST_A || fn == ALU_MUL, enA);
        checkBit("enB", dest == DEST_B, enB);
        checkBit("enC", dest == DEST_C, enC);
        checkBit("isMul", fn == ALU_MUL, isMul);
        checkBit("we", dest == DEST_ADR, we);
        checkSel("memAddr", (dest == DEST_ADR) ? MEM_FROM_A : MEM_FROM_PC, memAddr);
        nextCycle();
        checkState("back to fetch", FETCH, state);
    endtask

    task automatic aTypeExec();
        startTest("atype");
        runAtype(3'(nextRandom(4)), ALU_SUB, 2'(nextRandom(4)), DEST_A + 3'(nextRandom(3)));
        runAtype(3'(nextRandom(4)), ALU_MUL, 2'(nextRandom(4)), DEST_B);
        runAtype(3'd0, ALU_ADD, 2'd0, DEST_ZERO); // All-zero NOP
        runAtype(3'(nextRandom(4)), ALU_ADD, 2'(nextRandom(4)), DEST_ADR);
        endTest();
    endtask

    task automatic operandFetchModes();
        logic [1:0] fn;
        logic       hi, lo;
        logic [2:0] src, dest;
        startTest("operand fetch");
        fn = 2'(nextRandom(3)); // Never 11, so no LDI
        hi = 1'(nextRandom(2));
        waitForState(FETCH, 10);
        opcode = {2'b01, fn, SRC_IMMED, hi, 8'(nextRandom(256))};
        nextCycle();
        checkState("immediate read", RIMMED, state);
        checkBit("re", 1'b1, re);
        checkBit("saveMem", 1'b1, saveMem);
        checkBit("enPC", 1'b1, enPC);
        checkSel("memAddr", MEM_FROM_PC, memAddr);
        nextCycle();
        checkState("execute", ITYPE, state);
        checkSel("aluA", ALU_A_MEM, aluA);
        checkSel("aluB", ALU_B_OP, aluB);
        checkFunc("aluFunc", {hi, hi, fn}, aluFunc);
        checkBit("we to (A)", 1'b1, we); // s1 of 4 is also DEST_ADR
        nextCycle();
        checkState("back to fetch", FETCH, state);

        waitForState(FETCH, 10);
        opcode = {2'b01, fn, SRC_INDIRECT, hi, 8'(nextRandom(256))};
        nextCycle();
        checkState("indirect read", RADDRESS, state);
        checkSel("memAddr", MEM_FROM_A, memAddr);
        checkBit("re", 1'b1, re);
        checkBit("saveMem", 1'b1, saveMem);
        checkBit("enPC", 1'b0, enPC);
        nextCycle();
        checkState("execute", ITYPE, state);
        checkSel("aluA", ALU_A_MEM, aluA);

        waitForState(FETCH, 10);
        opcode = {2'b01, 2'b11, SRC_IMMED, 1'b1, 8'(nextRandom(256))}; // LDI
        nextCycle();
        checkState("LDI skips read", ITYPE, state);
        checkFunc("aluFunc", 4'hF, aluFunc);

        src  = 3'(nextRandom(4));
        dest = 3'(1 + nextRandom(3));
        hi   = 1'(nextRandom(2));
        lo   = 1'(nextRandom(2));
        waitForState(FETCH, 10);
        opcode = {4'b0001, src, hi, lo, dest, 4'(nextRandom(16))};
        nextCycle();
        checkState("execute", SITYPE, state);
        checkFunc("aluFunc", {2'b10, hi, lo}, aluFunc);
        checkSel("aluB", ALU_B_OP, aluB);
        checkBit("enA", dest == DEST_A, enA);
        checkBit("enB", dest == DEST_B, enB);
        checkBit("enC", dest == DEST_C, enC);
        endTest();
    endtask

    task automatic branchDecisions();
        logic [1:0] idx;
        logic       cond;
        logic       taken;
        logic [2:0] src;
        startTest("branch");
        repeat (8) begin
            waitForState(FETCH, 10);
            flags  = 4'(nextRandom(16));
            idx    = 2'(nextRandom(4));
            cond   = 1'(nextRandom(2));
            opcode = {4'b0010, cond, idx, 1'b0, 8'(nextRandom(256))};
            taken  = (flags[idx] == cond);
            nextCycle();
            if (taken) begin
                checkState("taken branch", FTYPE, state);
                checkBit("enPC", 1'b1, enPC);
                checkSel("aluB", ALU_B_OP, aluB);
                nextCycle();
            end
            checkState("fetch after branch", FETCH, state);
        end
        waitForState(FETCH, 10);
        opcode = {2'b11, 14'(nextRandom(16384))};
        nextCycle();
        checkState("jump", JMP, state);
        checkSel("aluA", ALU_A_PC, aluA);
        checkSel("aluB", ALU_B_ADDR, aluB);
        checkBit("enPC", 1'b1, enPC);
        src = 3'(nextRandom(4));
        waitForState(FETCH, 10);
        opcode = {4'b1000, src, 9'(nextRandom(512))};
        nextCycle();
        checkState("register jump", JMR, state);
        checkFunc("aluFunc", ALU_JREL, aluFunc);
        checkSel("aluB", SEL_W'(src), aluB);
        endTest();
    endtask

    task automatic stallHold();
        int n;
        startTest("stall");
        n = 1 + nextRandom(8);
        waitForState(FETCH, 10);
        opcode = {2'b01, 2'b00, SRC_IMMED, 1'b0, 8'(nextRandom(256))};
        @(negedge clk);
        stall = 1'b1;
        #1;
        checkState("entered read", RIMMED, state);
        repeat (n) begin
            nextCycle();
            checkState("held state", RIMMED, state);
            checkBit("re held", 1'b1, re);
            checkBit("saveMem held", 1'b1, saveMem);
            checkBit("enPC held", 1'b1, enPC);
            checkSel("aluA held", ALU_A_PC, aluA);
        end
        @(negedge clk);
        stall = 1'b0;
        #1;
        checkState("release cycle", RIMMED, state);
        nextCycle();
        checkState("resumed", ITYPE, state);
        nextCycle();
        checkState("back to fetch", FETCH, state);
        endTest();
    endtask

    task automatic runHalt(input logic [WORD_W-1:0] op);
        waitForState(FETCH, 10);
        opcode = op;
        nextCycle();
        checkState("halted", HALT, state);
        expectIdle();
        repeat (4) nextCycle();
        checkState("still halted", HALT, state);
        expectIdle();
        @(negedge clk);
        opcode = '0;
        applyReset();
    endtask

    task automatic haltOnIllegal();
        startTest("halt");
        runHalt({4'b1001, 12'(nextRandom(4096))});   // Unused class
        runHalt({4'b0000, 3'd5, 9'(nextRandom(512))}); // Absolute source mode
        endTest();
    endtask

    initial begin
        rst    = 1'b1;
        stall  = 1'b0;
        opcode = '0;
        flags  = '0;
        startTest("reset");
        applyReset();
        endTest();
        aTypeExec();
        operandFetchModes();
        branchDecisions();
        stallHold();
        haltOnIllegal();
        $display("%0d checks, %0d errors", checkCount, errCount);
        if (errCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
